/* source/rvdiv_settings.svh */
`ifndef RVDIV_SETTINGS_SVH
`define RVDIV_SETTINGS_SVH

// operand and result width
`define DIV_XLEN 32

// one register per divider cell plus the result stage
`define DIV_LATENCY (`DIV_XLEN + 1)

`endif

/* source/rvdiv_pkg.sv */
package rvdiv_pkg;

    // low two bits of funct3 for the M-extension divides
    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } div_op_e;

    typedef struct packed {
        logic sel_rem;      // 1 selects remainder
        logic is_unsigned;  // 1 for DIVU / REMU
    } div_op_fields_s;

    // one word read as a code or as decoded bits
    typedef union packed {
        div_op_e        code;
        div_op_fields_s fields;
    } div_op_u;

endpackage

/* source/divider_cell.sv */
`timescale 1ns/10ps
`include "rvdiv_settings.svh"

module divider_cell (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 en,
    input  logic [`DIV_XLEN:0]   partial,
    input  logic [`DIV_XLEN-1:0] divisor_in,
    input  logic [`DIV_XLEN-1:0] quot_in,
    input  logic [`DIV_XLEN-1:0] dividend_in,
    output logic                 valid,
    output logic [`DIV_XLEN-1:0] divisor_kp,
    output logic [`DIV_XLEN-1:0] quot,
    output logic [`DIV_XLEN-1:0] dividend_kp,
    output logic [`DIV_XLEN-1:0] rem
);

    logic                 fits;
    logic [`DIV_XLEN-1:0] diff;

    assign fits = (partial >= {1'b0, divisor_in});
    assign diff = partial[`DIV_XLEN-1:0] - divisor_in;  // exact whenever fits

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= 1'b0;
        end else begin
            valid <= en;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            quot        <= {quot_in[`DIV_XLEN-2:0], fits};  // new bit in at lsb
            rem         <= fits ? diff : partial[`DIV_XLEN-1:0];
            divisor_kp  <= divisor_in;
            dividend_kp <= dividend_in;
        end
    end

endmodule

/* source/div_array.sv */
`timescale 1ns/10ps
`include "rvdiv_settings.svh"

module div_array (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 in_valid,
    input  rvdiv_pkg::div_op_u   op,
    input  logic [`DIV_XLEN-1:0] dividend,
    input  logic [`DIV_XLEN-1:0] divisor,
    output logic                 arr_valid,
    output logic [`DIV_XLEN-1:0] quot_mag,
    output logic [`DIV_XLEN-1:0] rem_mag
);

    localparam int XLEN = `DIV_XLEN;

    logic                      is_signed;
    logic [XLEN-1:0]           dividend_abs;
    logic [XLEN-1:0]           divisor_abs;
    logic [XLEN-1:0]           valid_c;
    logic [XLEN-1:0][XLEN-1:0] divisor_c;
    logic [XLEN-1:0][XLEN-1:0] quot_c;
    logic [XLEN-1:0][XLEN-1:0] dividend_c;
    logic [XLEN-1:0][XLEN-1:0] rem_c;

    assign is_signed    = !op.fields.is_unsigned;
    assign dividend_abs = (is_signed && dividend[XLEN-1]) ? -dividend : dividend;
    assign divisor_abs  = (is_signed && divisor[XLEN-1]) ? -divisor : divisor;

    for (genvar i = 0; i < XLEN; i++) begin : g_step
        logic            en;
        logic [XLEN:0]   partial;
        logic [XLEN-1:0] divisor_in;
        logic [XLEN-1:0] quot_in;
        logic [XLEN-1:0] dividend_in;

        if (i == 0) begin : g_first
            assign en          = in_valid;
            assign partial     = {{XLEN{1'b0}}, dividend_abs[XLEN-1]};  // msb first
            assign divisor_in  = divisor_abs;
            assign quot_in     = '0;
            assign dividend_in = dividend_abs;
        end else begin : g_next
            assign en          = valid_c[i-1];
            assign partial     = {rem_c[i-1], dividend_c[i-1][XLEN-1-i]};
            assign divisor_in  = divisor_c[i-1];
            assign quot_in     = quot_c[i-1];
            assign dividend_in = dividend_c[i-1];
        end

        divider_cell u_cell (
            .clk         (clk),
            .rstn        (rstn),
            .en          (en),
            .partial     (partial),
            .divisor_in  (divisor_in),
            .quot_in     (quot_in),
            .dividend_in (dividend_in),
            .valid       (valid_c[i]),
            .divisor_kp  (divisor_c[i]),
            .quot        (quot_c[i]),
            .dividend_kp (dividend_c[i]),
            .rem         (rem_c[i])
        );
    end

    assign arr_valid = valid_c[XLEN-1];
    assign quot_mag  = quot_c[XLEN-1];
    assign rem_mag   = rem_c[XLEN-1];

endmodule

/* source/div_exception.sv */
`timescale 1ns/10ps
`include "rvdiv_settings.svh"

module div_exception (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 in_valid,
    input  rvdiv_pkg::div_op_u   op,
    input  logic [`DIV_XLEN-1:0] dividend,
    input  logic [`DIV_XLEN-1:0] divisor,
    output logic                 ex_valid,
    output rvdiv_pkg::div_op_u   ex_op,
    output logic                 neg_quot,
    output logic                 neg_rem,
    output logic                 div_zero,
    output logic                 overflow,
    output logic [`DIV_XLEN-1:0] ex_dividend
);

    import rvdiv_pkg::*;

    localparam int XLEN  = `DIV_XLEN;
    localparam int DEPTH = `DIV_LATENCY - 1;  // matches the cell chain

    logic             is_signed;
    logic [3:0]       flags_in;
    logic [DEPTH-1:0] vld_sr;
    div_op_u          op_sr  [DEPTH];
    logic [3:0]       flag_sr [DEPTH];
    logic [XLEN-1:0]  dvd_sr [DEPTH];

    assign is_signed = !op.fields.is_unsigned;
    // zero, overflow, quotient sign, remainder sign
    assign flags_in = {
        divisor == '0,
        is_signed && (dividend == {1'b1, {(XLEN-1){1'b0}}}) && (&divisor),
        is_signed && (dividend[XLEN-1] ^ divisor[XLEN-1]),
        is_signed && dividend[XLEN-1]
    };

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[DEPTH-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        op_sr[0]   <= op;
        flag_sr[0] <= flags_in;
        dvd_sr[0]  <= dividend;
        for (int i = 1; i < DEPTH; i++) begin
            op_sr[i]   <= op_sr[i-1];
            flag_sr[i] <= flag_sr[i-1];
            dvd_sr[i]  <= dvd_sr[i-1];
        end
    end

    assign ex_valid    = vld_sr[DEPTH-1];
    assign ex_op       = op_sr[DEPTH-1];
    assign ex_dividend = dvd_sr[DEPTH-1];
    assign {div_zero, overflow, neg_quot, neg_rem} = flag_sr[DEPTH-1];

endmodule

/* source/div_result.sv */
`timescale 1ns/10ps
`include "rvdiv_settings.svh"

module div_result (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 arr_valid,
    input  logic [`DIV_XLEN-1:0] quot_mag,
    input  logic [`DIV_XLEN-1:0] rem_mag,
    input  logic                 ex_valid,
    input  rvdiv_pkg::div_op_u   ex_op,
    input  logic                 neg_quot,
    input  logic                 neg_rem,
    input  logic                 div_zero,
    input  logic                 overflow,
    input  logic [`DIV_XLEN-1:0] ex_dividend,
    output logic                 res_valid,
    output logic [`DIV_XLEN-1:0] result
);

    logic [`DIV_XLEN-1:0] quot_fix;
    logic [`DIV_XLEN-1:0] rem_fix;

    always_comb begin
        quot_fix = neg_quot ? -quot_mag : quot_mag;
        rem_fix  = neg_rem ? -rem_mag : rem_mag;
        if (div_zero) begin
            quot_fix = '1;
            rem_fix  = ex_dividend;
        end else if (overflow) begin
            quot_fix = ex_dividend;  // most negative value
            rem_fix  = '0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= arr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            result <= ex_op.fields.sel_rem ? rem_fix : quot_fix;
        end
    end

endmodule

/* source/div_unit.sv */
`timescale 1ns/10ps
`include "rvdiv_settings.svh"

module div_unit (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 in_valid,
    input  rvdiv_pkg::div_op_u   op,
    input  logic [`DIV_XLEN-1:0] dividend,
    input  logic [`DIV_XLEN-1:0] divisor,
    output logic                 res_valid,
    output logic [`DIV_XLEN-1:0] result
);

    import rvdiv_pkg::*;

    logic                 arr_valid;
    logic [`DIV_XLEN-1:0] quot_mag;
    logic [`DIV_XLEN-1:0] rem_mag;
    logic                 ex_valid;
    div_op_u              ex_op;
    logic                 neg_quot;
    logic                 neg_rem;
    logic                 div_zero;
    logic                 overflow;
    logic [`DIV_XLEN-1:0] ex_dividend;

    div_array u_div_array (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .op        (op),
        .dividend  (dividend),
        .divisor   (divisor),
        .arr_valid (arr_valid),
        .quot_mag  (quot_mag),
        .rem_mag   (rem_mag)
    );

    div_exception u_div_exception (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (in_valid),
        .op          (op),
        .dividend    (dividend),
        .divisor     (divisor),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .neg_quot    (neg_quot),
        .neg_rem     (neg_rem),
        .div_zero    (div_zero),
        .overflow    (overflow),
        .ex_dividend (ex_dividend)
    );

    div_result u_div_result (
        .clk         (clk),
        .rstn        (rstn),
        .arr_valid   (arr_valid),
        .quot_mag    (quot_mag),
        .rem_mag     (rem_mag),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .neg_quot    (neg_quot),
        .neg_rem     (neg_rem),
        .div_zero    (div_zero),
        .overflow    (overflow),
        .ex_dividend (ex_dividend),
        .res_valid   (res_valid),
        .result      (result)
    );

endmodule

/* bench/div_unit_sva.sv */
`timescale 1ns/10ps
`include "rvdiv_settings.svh"

module div_unit_sva (
    input logic clk,
    input logic rstn,
    input logic in_valid,
    input logic arr_valid,
    input logic ex_valid,
    input logic res_valid
);

    localparam int LAT = `DIV_LATENCY;

    int unsigned since_rst;  // saturates at LAT
    int unsigned n_fail = 0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            since_rst <= 0;
        end else if (since_rst < LAT) begin
            since_rst <= since_rst + 1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rstn |-> !res_valid)
        else begin
            n_fail++;
            $error("res_valid high while in reset");
        end

    a_cold_start: assert property (@(posedge clk) disable iff (!rstn)
        (since_rst < LAT) |-> !res_valid)
        else begin
            n_fail++;
            $error("res_valid high before a full latency out of reset");
        end

    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        (since_rst == LAT) |-> (res_valid == $past(in_valid, LAT)))
        else begin
            n_fail++;
            $error("res_valid does not follow in_valid by the latency");
        end

    a_paths_agree: assert property (@(posedge clk) arr_valid == ex_valid)
        else begin
            n_fail++;
            $error("array and exception valid bits differ");
        end

endmodule

bind div_unit div_unit_sva u_div_unit_sva (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .arr_valid (arr_valid),
    .ex_valid  (ex_valid),
    .res_valid (res_valid)
);

/* bench/div_unit_tb.sv */
`timescale 1ns/10ps
`include "rvdiv_settings.svh"

module div_unit_tb;

    import rvdiv_pkg::*;

    localparam int XLEN       = `DIV_XLEN;
    localparam int LAT        = `DIV_LATENCY;
    localparam int N_STREAM   = 200;
    localparam int MAX_CYCLES = 2 * (N_STREAM + 64 + 8 * (LAT + 8));  // ops plus drains
    localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic            clk;
    logic            rstn;
    logic            in_valid;
    div_op_u         op;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
    logic            res_valid;
    logic [XLEN-1:0] result;

    logic [XLEN-1:0] exp_q[$];
    string           cur_test;
    int unsigned     cycle;
    int unsigned     n_checks;
    int unsigned     n_errors;
    int unsigned     err_base;
    bit              mark_armed;
    bit              rise_watch;
    int unsigned     mark_cycle;
    int unsigned     rise_cycle;

    div_unit u_div_unit (
        .clk(clk), .rstn(rstn), .in_valid(in_valid), .op(op),
        .dividend(dividend), .divisor(divisor), .res_valid(res_valid), .result(result)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // RISC-V M rules decoded from the code view
    function automatic logic [XLEN-1:0] ref_div(input div_op_u o, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [XLEN-1:0] q;
        logic [XLEN-1:0] r;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (o.code == OP_DIVU || o.code == OP_REMU) begin
            q = a / b;
            r = a % b;
        end else if (a == MIN_NEG && b == '1) begin
            q = a;
            r = '0;
        end else begin
            q = $signed(a) / $signed(b);  // truncates toward zero
            r = $signed(a) % $signed(b);
        end
        return (o.code == OP_REM || o.code == OP_REMU) ? r : q;
    endfunction

    task automatic check_word(input string what, input logic [XLEN-1:0] exp_v,
                              input logic [XLEN-1:0] act_v);
        n_checks++;
        if (act_v !== exp_v) begin
            n_errors++;
            $display("ERROR %s: expected %h, actual %h", what, exp_v, act_v);
        end
    endtask

    task automatic check_valid(input string what, input logic exp_v, input logic act_v);
        n_checks++;
        if (act_v !== exp_v) begin
            n_errors++;
            $display("ERROR %s: expected %b, actual %b", what, exp_v, act_v);
        end
    endtask

    // outputs settle half a cycle after the edge
    always @(negedge clk) begin
        if (mark_armed && in_valid) begin
            mark_cycle = cycle;
            mark_armed = 1'b0;
            rise_watch = 1'b1;
        end
        if (rise_watch && res_valid) begin
            rise_cycle = cycle;
            rise_watch = 1'b0;
        end
        if (rstn && res_valid) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("%s: result valid with no operation outstanding", cur_test);
            end else begin
                check_word(cur_test, exp_q.pop_front(), result);
            end
        end
    end

    task automatic issue(input div_op_e code, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b);
        div_op_u o;
        o.code = code;
        @(posedge clk);
        in_valid <= 1'b1;
        op       <= o;
        dividend <= a;
        divisor  <= b;
        exp_q.push_back(ref_div(o, a, b));
    endtask

    task automatic issue_div_rem(input div_op_e qop, input div_op_e rop,
                                 input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        issue(qop, a, b);
        issue(rop, a, b);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_base = n_errors;
    endtask

    task automatic finish_test();
        int unsigned waited;
        waited = 0;
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0 && waited < LAT + N_STREAM) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            n_errors++;
            $display("%s: %0d results never came back", cur_test, exp_q.size());
            exp_q.delete();
        end
        repeat (4) @(negedge clk);  // catch stray strobes
        $display("test %-12s %s", cur_test, (n_errors == err_base) ? "pass" : "fail");
    endtask

    task automatic test_unsigned();
        start_test("unsigned");
        issue_div_rem(OP_DIVU, OP_REMU, 100, 7);
        issue_div_rem(OP_DIVU, OP_REMU, 7, 100);
        issue_div_rem(OP_DIVU, OP_REMU, '1, 1);
        issue_div_rem(OP_DIVU, OP_REMU, '1, 16);
        issue_div_rem(OP_DIVU, OP_REMU, MIN_NEG, 3);
        issue_div_rem(OP_DIVU, OP_REMU, 12345678, 12345678);
        finish_test();
    endtask

    task automatic test_signed();
        start_test("signed");
        issue_div_rem(OP_DIV, OP_REM, 20, 6);
        issue_div_rem(OP_DIV, OP_REM, -20, 6);
        issue_div_rem(OP_DIV, OP_REM, 20, -6);
        issue_div_rem(OP_DIV, OP_REM, -20, -6);
        issue_div_rem(OP_DIV, OP_REM, -7, 7);
        issue_div_rem(OP_DIV, OP_REM, MIN_NEG, 3);
        finish_test();
    endtask

    task automatic test_div_zero();
        start_test("div_zero");
        issue_div_rem(OP_DIV, OP_REM, 1234, 0);
        issue_div_rem(OP_DIVU, OP_REMU, -5, 0);
        issue_div_rem(OP_DIV, OP_REM, MIN_NEG, 0);
        finish_test();
    endtask

    task automatic test_overflow();
        start_test("overflow");
        issue_div_rem(OP_DIV, OP_REM, MIN_NEG, '1);
        issue_div_rem(OP_DIVU, OP_REMU, MIN_NEG, '1);  // plain unsigned result
        finish_test();
    endtask

    task automatic test_stream();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        div_op_e         code;
        start_test("stream");
        mark_cycle = 0;
        rise_cycle = 0;
        mark_armed = 1'b1;
        for (int i = 0; i < N_STREAM; i++) begin
            code = div_op_e'(2'($urandom_range(3, 0)));
            a    = $urandom;
            b    = $urandom;
            case ($urandom_range(7, 0))
                0: b = '0;
                1: b = $urandom_range(15, 1);
                2: begin
                    a = MIN_NEG;
                    b = '1;
                end
                default: ;
            endcase
            issue(code, a, b);
        end
        check_word({cur_test, " latency"}, LAT, rise_cycle - mark_cycle);
        finish_test();
    endtask

    task automatic test_idle_reset();
        start_test("idle_reset");
        repeat (LAT + 4) begin
            @(negedge clk);
            check_valid({cur_test, " idle"}, 1'b0, res_valid);
        end
        for (int i = 0; i < 10; i++) begin
            issue(OP_DIVU, $urandom, i + 1);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        rstn     <= 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        exp_q.delete();  // in-flight ops dropped by reset
        repeat (LAT + 4) begin
            @(negedge clk);
            check_valid({cur_test, " flushed"}, 1'b0, res_valid);
        end
        issue(OP_REM, -17, 5);  // unit recovers
        finish_test();
    endtask

    initial begin
        void'($urandom(32'h3b94294a));
        clk        = 1'b0;
        rstn       = 1'b0;
        in_valid   = 1'b0;
        op         = '0;
        dividend   = '0;
        divisor    = '0;
        cycle      = 0;
        n_checks   = 0;
        n_errors   = 0;
        mark_armed = 1'b0;
        rise_watch = 1'b0;
        cur_test   = "reset";
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        test_unsigned();
        test_signed();
        test_div_zero();
        test_overflow();
        test_stream();
        test_idle_reset();
        $display("%0d checks, %0d errors, %0d assertion failures",
                 n_checks, n_errors, u_div_unit.u_div_unit_sva.n_fail);
        if (n_errors == 0 && u_div_unit.u_div_unit_sva.n_fail == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+source
source/rvdiv_pkg.sv
source/divider_cell.sv
source/div_array.sv
source/div_exception.sv
source/div_result.sv
source/div_unit.sv
bench/div_unit_sva.sv
bench/div_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
